/* include/cart_settings.svh */
// cartridge core constants, include wherever widths, region codes or header offsets are needed
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ----------------------------------------
// clocking
// ----------------------------------------
`define CE_DIV 8 // clk_sys cycles per cpu strobe

// ----------------------------------------
// address widths
// ----------------------------------------
`define CART_ADDR_W 16 // cpu byte address
`define MEM_ADDR_W 24 // external memory word address
`define DL_ADDR_W 25 // download byte address

// header words inside the rom image, byte addresses of the download
`define HDR_TYPE_ADDR 25'h146 // high byte holds the mbc type
`define HDR_SIZE_ADDR 25'h148 // low byte rom size, high byte ram size

// ----------------------------------------
// cpu write regions, addr[15:13]
// ----------------------------------------
`define REG_RAM_EN 3'd0 // 0000-1fff
`define REG_ROM_BANK 3'd1 // 2000-3fff
`define REG_RAM_BANK 3'd2 // 4000-5fff
`define REG_MODE 3'd3 // 6000-7fff
`define REG_RAM_WIN 3'd5 // a000-bfff external ram window

// addr[15:9] of the built-in mbc2 ram, a000-a1ff
`define MBC2_RAM_TOP 7'b1010000

// bank 0 is never selected in the switchable slot on mbc1..mbc3
`define ROM_BANK_RESET 7'd1

`endif

/* src/cart_pkg.sv */
// shared types of the cartridge core, imported by each module that uses them
`include "cart_settings.svh"

package cart_pkg;

	// mapper chip family, decoded from the header type byte
	typedef enum logic [2:0] {
		mbc_none = 3'd0,
		mbc1 = 3'd1,
		mbc2 = 3'd2,
		mbc3 = 3'd3,
		mbc5 = 3'd4
	} mbc_kind_t;

	// raw header bytes captured while the image streams in
	typedef struct packed {
		logic [7:0] mbc_type; // 0147
		logic [7:0] rom_size; // 0148
		logic [7:0] ram_size; // 0149
	} cart_header_t;

	// mirroring masks derived from the sizes
	typedef struct packed {
		logic [6:0] rom_mask;
		logic [1:0] ram_mask;
	} bank_masks_t;

	// ----------------------------------------
	// mapper register file
	// ----------------------------------------
	typedef struct packed {
		logic [6:0] rom_bank;
		logic [1:0] ram_bank;
		logic mbc1_mode; // 0 = 16/8 mode, 1 = 4/32 mode
		logic rtc_select; // mbc3 only, unmaps the ram window
		logic ram_enable;
	} bank_regs_t;

	// cpu side of the cartridge slot
	typedef struct packed {
		logic [`CART_ADDR_W-1:0] addr;
		logic [7:0] data; // cpu to cart
		logic rd;
		logic wr;
	} cpu_bus_t;

	// one word of the streamed image
	typedef struct packed {
		logic [`DL_ADDR_W-1:0] addr; // byte address, always even
		logic [15:0] data;
	} dl_word_t;

	// request to the external word memory
	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] addr; // word address
		logic [15:0] data;
		logic [1:0] ds; // byte select, bit 1 = high byte
		logic we;
		logic oe;
	} mem_req_t;

endpackage

/* src/ce_divider.sv */
// cpu clock-enable generator, one strobe every CE_DIV system clocks
`include "cart_settings.svh"
`timescale 1ns/1ns

module ce_divider (
	input logic clk_sys,
	input logic reset,
	output logic ce_cpu
);

	localparam int CNT_W = $clog2(`CE_DIV);

	logic [CNT_W-1:0] cnt; // free running, wraps at CE_DIV-1

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt <= '0;
		end else if (cnt == CNT_W'(`CE_DIV - 1)) begin
			cnt <= '0; // terminal count, start next period
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign ce_cpu = (cnt == CNT_W'(`CE_DIV - 1)); // single cycle pulse

	// the memory and the mapper both count on a strobe being one clock wide
	a_ce_single: assert property (@(posedge clk_sys) disable iff (reset)
		ce_cpu |=> !ce_cpu)
		else $error("ce_cpu high on two consecutive cycles");

endmodule

/* src/download_fsm.sv */
// sequences streamed image words into memory, one per cpu strobe, and flags the cart ready
`timescale 1ns/1ns

module download_fsm (
	input logic clk_sys,
	input logic reset,
	input logic ce_cpu,
	input logic cart_download,
	input logic ioctl_wr,
	output logic ioctl_wait,
	output logic dl_we,
	output logic cart_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait, // word held, waiting for a strobe to line up
		st_write // write request out for one full strobe period
	} state_t;

	state_t state;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
			cart_ready <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (cart_download && ioctl_wr) state <= st_wait;
				end
				st_wait: begin
					if (ce_cpu) state <= st_write; // align to strobe boundary
				end
				st_write: begin
					// this strobe is the memory commit
					if (ce_cpu) begin
						state <= st_idle;
						cart_ready <= 1'b1; // sticky until reset
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign ioctl_wait = (state != st_idle); // source holds off while busy
	assign dl_we = (state == st_write);

	// the source is expected to honour the wait level
	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> !ioctl_wait)
		else $error("ioctl_wr pulsed while ioctl_wait was high");

endmodule

/* src/cart_header.sv */
// snoops the download for the cartridge header and decodes mapper kind and bank masks
`include "cart_settings.svh"
`timescale 1ns/1ns

module cart_header import cart_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic cart_download,
	input logic ioctl_wr,
	input dl_word_t dl,
	output mbc_kind_t kind,
	output bank_masks_t masks
);

	cart_header_t hdr;

	// ----------------------------------------
	// capture
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr <= '0;
		end else if (cart_download && ioctl_wr) begin
			case (dl.addr)
				`HDR_TYPE_ADDR: hdr.mbc_type <= dl.data[15:8]; // byte 0147
				`HDR_SIZE_ADDR: begin
					hdr.rom_size <= dl.data[7:0]; // byte 0148
					hdr.ram_size <= dl.data[15:8]; // byte 0149
				end
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// decode
	// ----------------------------------------
	always_comb begin
		case (hdr.mbc_type) inside
			[8'h01:8'h03]: kind = mbc1; // plain, +ram, +ram+battery
			[8'h05:8'h06]: kind = mbc2;
			[8'h0f:8'h13]: kind = mbc3; // with or without timer
			[8'h19:8'h1e]: kind = mbc5; // rumble variants included
			default: kind = mbc_none; // rom only and unsupported chips
		endcase
	end

	always_comb begin
		case (hdr.rom_size)
			8'h00: masks.rom_mask = 7'b0000001; // 32k, 2 banks
			8'h01: masks.rom_mask = 7'b0000011; // 64k
			8'h02: masks.rom_mask = 7'b0000111; // 128k
			8'h03: masks.rom_mask = 7'b0001111; // 256k
			8'h04: masks.rom_mask = 7'b0011111; // 512k
			8'h05: masks.rom_mask = 7'b0111111; // 1M
			8'h06: masks.rom_mask = 7'b1111111; // 2M, 128 banks
			8'h52: masks.rom_mask = 7'b1000111; // 72 banks
			8'h53: masks.rom_mask = 7'b1001111; // 80 banks
			default: masks.rom_mask = 7'b1011111; // 96 banks
		endcase
		// up to 8k is a single bank, larger parts get four
		masks.ram_mask = (hdr.ram_size <= 8'd2) ? 2'b00 : 2'b11;
	end

endmodule

/* src/mbc_regs.sv */
// mapper bank registers, loaded by cpu stores into the rom area on the cpu strobe
`include "cart_settings.svh"
`timescale 1ns/1ns

module mbc_regs import cart_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic ce_cpu,
	input logic cart_download,
	input cpu_bus_t cpu,
	input mbc_kind_t kind,
	output bank_regs_t regs
);

	logic [2:0] region;

	assign region = cpu.addr[15:13];

	always_ff @(posedge clk_sys) begin
		// a new image starts from power-on state
		if (reset || cart_download) begin
			regs.rom_bank <= `ROM_BANK_RESET;
			regs.ram_bank <= 2'd0;
			regs.mbc1_mode <= 1'b0;
			regs.rtc_select <= 1'b0;
			regs.ram_enable <= 1'b0;
		end else if (ce_cpu && cpu.wr) begin
			case (region)
				`REG_RAM_EN: begin
					regs.ram_enable <= (cpu.data[3:0] == 4'ha); // only 0a unlocks
				end
				`REG_ROM_BANK: begin
					// bank 0 maps to 1 except on mbc5, which may select it
					if (kind != mbc5 && cpu.data[4:0] == 5'd0) begin
						regs.rom_bank <= `ROM_BANK_RESET;
					end else begin
						regs.rom_bank <= cpu.data[6:0];
					end
				end
				`REG_RAM_BANK: begin
					if (kind == mbc3 && cpu.data[3]) begin
						regs.rtc_select <= 1'b1; // 08-0c select a clock register
					end else begin
						if (kind == mbc3) regs.rtc_select <= 1'b0;
						regs.ram_bank <= cpu.data[1:0];
					end
				end
				`REG_MODE: begin
					if (kind == mbc1) regs.mbc1_mode <= cpu.data[0]; // rom/ram mode select
				end
				default: ; // writes elsewhere hit cart ram or nothing
			endcase
		end
	end

	// holds across the kind decode in cart_header as well as the store rule above
	a_mbc1_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		(kind == mbc1) |-> (regs.rom_bank[4:0] != 5'd0))
		else $error("mbc1 rom bank low bits are zero");

endmodule

/* src/cart_mapper.sv */
// bank address mapping, memory request mux and cpu read data formatting, all combinational
`include "cart_settings.svh"
`timescale 1ns/1ns

module cart_mapper import cart_pkg::*; (
	input logic cart_download,
	input dl_word_t dl,
	input logic dl_we,
	input cpu_bus_t cpu,
	input bank_regs_t regs,
	input mbc_kind_t kind,
	input bank_masks_t masks,
	input logic cart_ready,
	input logic [15:0] mem_rdata,
	output mem_req_t mem,
	output logic [7:0] cart_do
);

	logic [2:0] region;
	logic ram_win; // a000-bfff
	logic mbc2_ram; // a000-a1ff, 512x4 inside the mbc2 chip
	logic [6:0] rom_bank; // after mode select and mirroring
	logic [1:0] ram_bank;
	logic [8:0] bank;
	logic ram_wr;

	assign region = cpu.addr[15:13];
	assign ram_win = (region == `REG_RAM_WIN);
	assign mbc2_ram = (cpu.addr[15:9] == `MBC2_RAM_TOP);

	// ----------------------------------------
	// bank selection
	// ----------------------------------------
	always_comb begin
		// mbc1 mode 0 uses the ram bank bits as upper rom lines
		if (kind == mbc1) begin
			rom_bank = {regs.mbc1_mode ? 2'b00 : regs.ram_bank, regs.rom_bank[4:0]};
			ram_bank = regs.mbc1_mode ? regs.ram_bank : 2'b00;
		end else begin
			rom_bank = regs.rom_bank;
			ram_bank = regs.ram_bank;
		end
		rom_bank = rom_bank & masks.rom_mask; // mirror small roms
		ram_bank = ram_bank & masks.ram_mask;

		if (kind == mbc_none) begin
			bank = {7'd0, cpu.addr[14:13]}; // 32k linear
		end else if (cpu.addr[15:14] == 2'b00) begin
			bank = {8'd0, cpu.addr[13]}; // fixed bank 0
		end else if (cpu.addr[15:14] == 2'b01) begin
			bank = {1'b0, rom_bank, cpu.addr[13]}; // switchable 16k
		end else if (ram_win) begin
			if (kind == mbc2) bank = mbc2_ram ? 9'b100000000 : 9'd0;
			else if (kind == mbc3 && regs.rtc_select) bank = 9'd0; // clock, no ram
			else bank = {7'b1000000, ram_bank};
		end else begin
			bank = 9'd0;
		end
	end

	// only stores into an enabled ram window reach memory
	assign ram_wr = cpu.wr && regs.ram_enable && ram_win;

	// ----------------------------------------
	// memory request
	// ----------------------------------------
	always_comb begin
		if (cart_download) begin
			mem.addr = dl.addr[`DL_ADDR_W-1:1]; // byte to word address
			mem.data = dl.data;
			mem.ds = 2'b11;
			mem.we = dl_we;
			mem.oe = 1'b0;
		end else begin
			mem.addr = {3'b000, bank, cpu.addr[12:1]};
			mem.data = {cpu.data, cpu.data}; // byte lane picked by ds
			mem.ds = {cpu.addr[0], ~cpu.addr[0]};
			mem.we = ram_wr;
			mem.oe = cpu.rd;
		end
	end

	// cpu read data
	always_comb begin
		if (!cart_ready) begin
			cart_do = 8'h00; // nothing loaded yet
		end else if (ram_win && !regs.ram_enable) begin
			cart_do = 8'hff; // locked ram reads as open bus
		end else if (kind == mbc2 && mbc2_ram) begin
			cart_do = {4'hf, cpu.addr[0] ? mem_rdata[11:8] : mem_rdata[3:0]}; // 4 bit cells
		end else begin
			cart_do = cpu.addr[0] ? mem_rdata[15:8] : mem_rdata[7:0];
		end
	end

	// the cpu bus must never ask for a read and a ram write at once
	always_comb begin
		a_no_we_oe: assert #0 (!(mem.we && mem.oe))
			else $error("memory we and oe high together");
	end

endmodule

/* src/cart_top.sv */
// cartridge side of the console core, connects strobe, download, header, registers and mapper
`timescale 1ns/1ns

module cart_top import cart_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic cart_download, // level, high for the whole image
	input logic ioctl_wr,
	input dl_word_t dl,
	input cpu_bus_t cpu,
	input logic [15:0] mem_rdata,
	output logic ioctl_wait,
	output logic ce_cpu,
	output logic cart_ready,
	output logic [7:0] cart_do,
	output mem_req_t mem
);

	logic dl_we;
	mbc_kind_t kind;
	bank_masks_t masks;
	bank_regs_t regs;

	// ----------------------------------------
	// timing and download
	// ----------------------------------------
	ce_divider i_ce_divider (
		.clk_sys (clk_sys),
		.reset (reset),
		.ce_cpu (ce_cpu)
	);

	download_fsm i_download_fsm (
		.clk_sys (clk_sys),
		.reset (reset),
		.ce_cpu (ce_cpu),
		.cart_download (cart_download),
		.ioctl_wr (ioctl_wr),
		.ioctl_wait (ioctl_wait),
		.dl_we (dl_we),
		.cart_ready (cart_ready)
	);

	cart_header i_cart_header (
		.clk_sys (clk_sys),
		.reset (reset),
		.cart_download (cart_download),
		.ioctl_wr (ioctl_wr),
		.dl (dl),
		.kind (kind),
		.masks (masks)
	);

	// ----------------------------------------
	// mapper
	// ----------------------------------------
	mbc_regs i_mbc_regs (
		.clk_sys (clk_sys),
		.reset (reset),
		.ce_cpu (ce_cpu),
		.cart_download (cart_download),
		.cpu (cpu),
		.kind (kind),
		.regs (regs)
	);

	cart_mapper i_cart_mapper (
		.cart_download (cart_download),
		.dl (dl),
		.dl_we (dl_we),
		.cpu (cpu),
		.regs (regs),
		.kind (kind),
		.masks (masks),
		.cart_ready (cart_ready),
		.mem_rdata (mem_rdata),
		.mem (mem),
		.cart_do (cart_do)
	);

endmodule

/* verification/cart_tb.sv */
// self-checking testbench for the cartridge core, compile with files.f and run cart_tb as top
`include "cart_settings.svh"
`timescale 1ns/1ns

module cart_tb import cart_pkg::*; ();

	localparam int IMG_WORDS = 64; // image body, two header words come on top
	localparam int NUM_DL = 6;
	// worst case 17 cycles per word plus the pulse and some slack
	localparam int DL_CYCLES = (IMG_WORDS + 2) * (2 * `CE_DIV + 4);
	localparam int TIMEOUT_CYCLES = 16 + NUM_DL * DL_CYCLES + 4000; // reads and stores < 4000

	logic clk_sys = 1'b0;
	logic reset;
	logic cart_download;
	logic ioctl_wr;
	dl_word_t dl;
	cpu_bus_t cpu;
	logic [15:0] mem_rdata;
	logic ioctl_wait;
	logic ce_cpu;
	logic cart_ready;
	logic [7:0] cart_do;
	mem_req_t mem;

	// ----------------------------------------
	// reference state
	// ----------------------------------------
	cart_header_t hdr; // header bytes of the last image sent
	bank_regs_t shadow; // mapper registers as the stores should leave them
	logic ready_exp;
	logic [15:0] img [IMG_WORDS];
	logic [31:0] lcg_state = 32'h6977_2f36;
	logic [15:0] mem_model [logic [23:0]]; // sparse, keyed by word address
	int mem_writes = 0;
	int errors = 0;
	int cycle_cnt = 0;
	int ce_phase = 0; // clocks since reset fell, modulo the strobe period

	cart_top i_cart_top (
		.clk_sys (clk_sys),
		.reset (reset),
		.cart_download (cart_download),
		.ioctl_wr (ioctl_wr),
		.dl (dl),
		.cpu (cpu),
		.mem_rdata (mem_rdata),
		.ioctl_wait (ioctl_wait),
		.ce_cpu (ce_cpu),
		.cart_ready (cart_ready),
		.cart_do (cart_do),
		.mem (mem)
	);

	always #2 clk_sys = ~clk_sys; // 4 ns period

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "run timed out");
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ----------------------------------------
	// memory model
	// ----------------------------------------
	function automatic logic [15:0] mem_word(input logic [23:0] wa);
		if (mem_model.exists(wa)) return mem_model[wa];
		return wa[15:0] ^ {wa[23:16], wa[23:16]} ^ 16'h3c5a; // fill for untouched words
	endfunction

	always @(posedge clk_sys) begin : mem_write
		logic [15:0] w;
		if (ce_cpu && mem.we) begin // commit on the strobe only
			w = mem_word(mem.addr);
			if (mem.ds[1]) w[15:8] = mem.data[15:8];
			if (mem.ds[0]) w[7:0] = mem.data[7:0];
			mem_model[mem.addr] = w;
			mem_writes = mem_writes + 1;
		end
	end

	always @(mem or mem_writes) begin
		mem_rdata = mem_word(mem.addr); // combinational read
	end

	// ----------------------------------------
	// reference
	// ----------------------------------------
	function automatic mbc_kind_t kind_of(input logic [7:0] t);
		if (t inside {[8'h01:8'h03]}) return mbc1;
		if (t inside {[8'h05:8'h06]}) return mbc2;
		if (t inside {[8'h0f:8'h13]}) return mbc3;
		if (t inside {[8'h19:8'h1e]}) return mbc5;
		return mbc_none;
	endfunction

	function automatic logic [6:0] rom_mask_of(input logic [7:0] s);
		if (s <= 8'd6) return 7'((32'd2 << s) - 32'd1); // n+1 low bits
		if (s == 8'h52) return 7'h47;
		if (s == 8'h53) return 7'h4f;
		return 7'h5f;
	endfunction

	function automatic logic [8:0] exp_bank(input cart_header_t h, input bank_regs_t r,
			input logic [15:0] a);
		mbc_kind_t k;
		logic [6:0] rb;
		logic [1:0] xb;
		k = kind_of(h.mbc_type);
		rb = (k == mbc1) ? {(r.mbc1_mode ? 2'b00 : r.ram_bank), r.rom_bank[4:0]} : r.rom_bank;
		xb = (k == mbc1 && !r.mbc1_mode) ? 2'b00 : r.ram_bank;
		rb = rb & rom_mask_of(h.rom_size);
		xb = xb & ((h.ram_size > 8'd2) ? 2'b11 : 2'b00);
		if (k == mbc_none) return {7'd0, a[14:13]};
		if (a < 16'h4000) return {8'd0, a[13]};
		if (a < 16'h8000) return {1'b0, rb, a[13]};
		if (a[15:13] != 3'd5) return 9'd0;
		if (k == mbc2) return (a[15:9] == 7'h50) ? 9'h100 : 9'h000;
		if (k == mbc3 && r.rtc_select) return 9'd0; // clock selected, no ram
		return {7'b1000000, xb};
	endfunction

	function automatic logic [7:0] exp_do(input cart_header_t h, input bank_regs_t r,
			input logic rdy, input logic [15:0] a);
		logic [15:0] w;
		w = mem_word({3'b000, exp_bank(h, r, a), a[12:1]});
		if (!rdy) return 8'h00;
		if (a[15:13] == 3'd5 && !r.ram_enable) return 8'hff;
		if (kind_of(h.mbc_type) == mbc2 && a[15:9] == 7'h50) begin
			return {4'hf, a[0] ? w[11:8] : w[3:0]};
		end
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic shadow_store(input logic [15:0] a, input logic [7:0] d);
		mbc_kind_t k;
		k = kind_of(hdr.mbc_type);
		case (a[15:13])
			3'd0: shadow.ram_enable = (d[3:0] == 4'ha);
			3'd1: shadow.rom_bank = (k != mbc5 && d[4:0] == 5'd0) ? 7'd1 : d[6:0];
			3'd2: begin
				if (k == mbc3 && d[3]) begin
					shadow.rtc_select = 1'b1;
				end else begin
					if (k == mbc3) shadow.rtc_select = 1'b0;
					shadow.ram_bank = d[1:0];
				end
			end
			3'd3: if (k == mbc1) shadow.mbc1_mode = d[0];
			default: ;
		endcase
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at the first failing check");
		end
	endtask

	// compare process, one sample per read window at the falling edge
	always @(negedge clk_sys) begin
		if (!reset && cpu.rd) begin
			check_eq({mem.we, mem.oe}, 2'b01, "read request strobes");
			check_eq(mem.addr, {3'b000, exp_bank(hdr, shadow, cpu.addr), cpu.addr[12:1]},
				$sformatf("memory address for cpu read of %h", cpu.addr));
			check_eq(cart_do, exp_do(hdr, shadow, ready_exp, cpu.addr),
				$sformatf("cart_do for cpu read of %h", cpu.addr));
		end
	end

	// strobe timing, first pulse in the eighth cycle after reset falls
	always @(negedge clk_sys) begin
		if (reset) begin
			ce_phase = 0;
		end else begin
			check_eq(ce_cpu, ce_phase == `CE_DIV - 1,
				$sformatf("ce_cpu at strobe phase %0d", ce_phase));
			ce_phase = (ce_phase + 1) % `CE_DIV;
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic step();
		@(posedge clk_sys);
		#1; // inputs move 1 ns after the edge
	endtask

	task automatic send_word(input logic [24:0] a, input logic [15:0] d);
		int lat;
		dl.addr = a;
		dl.data = d;
		ioctl_wr = 1'b1;
		step();
		ioctl_wr = 1'b0;
		lat = 0;
		while (ioctl_wait) begin // hold the word until the sequencer lets go
			step();
			lat++;
		end
		check_eq(lat inside {[9:17]}, 1'b1, $sformatf("ioctl_wait latency %0d", lat));
	endtask

	task automatic download(input logic [7:0] mtype, input logic [7:0] rsize,
			input logic [7:0] xsize);
		cart_download = 1'b1;
		hdr = {mtype, rsize, xsize};
		shadow = '0;
		shadow.rom_bank = 7'd1; // registers restart with every image
		for (int i = 0; i < IMG_WORDS; i++) begin
			lcg_state = lcg_next(lcg_state);
			img[i] = lcg_state[31:16];
			send_word(25'(2 * i), img[i]);
		end
		send_word(`HDR_TYPE_ADDR, {mtype, 8'h00});
		send_word(`HDR_SIZE_ADDR, {xsize, rsize});
		step();
		cart_download = 1'b0;
		ready_exp = 1'b1;
		check_eq(cart_ready, 1'b1, "cart_ready after download");
		// word lands at half its byte address
		for (int i = 0; i < IMG_WORDS; i++) begin
			check_eq(mem_word(24'(i)), img[i], $sformatf("image word %0d in memory", i));
		end
		check_eq(mem_word(24'h0000a3), {mtype, 8'h00}, "type header word in memory");
		check_eq(mem_word(24'h0000a4), {xsize, rsize}, "size header word in memory");
	endtask

	task automatic cpu_read(input logic [15:0] a);
		cpu.addr = a;
		cpu.rd = 1'b1;
		step();
		cpu.rd = 1'b0;
	endtask

	task automatic read_range(input logic [15:0] a, input int n);
		for (int i = 0; i < n; i++) cpu_read(a + 16'(i));
	endtask

	// eight cycles so exactly one strobe sees the store
	task automatic cpu_store(input logic [15:0] a, input logic [7:0] d);
		cpu.addr = a;
		cpu.data = d;
		cpu.wr = 1'b1;
		repeat (`CE_DIV) step();
		cpu.wr = 1'b0;
		shadow_store(a, d);
	endtask

	task automatic bank_sweep();
		logic [7:0] vals [3] = '{8'd0, 8'd5, 8'd127};
		foreach (vals[i]) begin
			cpu_store(16'h2000, vals[i]);
			cpu_read(16'h4000);
			cpu_read(16'h4001);
			cpu_read(16'h6000);
			cpu_read(16'h7fff);
		end
	endtask

	initial begin
		int wr_before;
		reset = 1'b1;
		cart_download = 1'b0;
		ioctl_wr = 1'b0;
		dl = '0;
		cpu = '0;
		mem_rdata = '0;
		hdr = '0;
		shadow = '0;
		shadow.rom_bank = 7'd1;
		ready_exp = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// no image yet, everything reads 00
		read_range(16'h0000, 4);
		read_range(16'h4000, 4);
		read_range(16'ha000, 4);
		check_eq(cart_ready, 1'b0, "cart_ready before download");

		download(8'h00, 8'h02, 8'h00); // rom only, 128k
		read_range(16'h0000, 2 * IMG_WORDS);
		bank_sweep();

		// ----------------------------------------
		// mbc1, 128k rom, 32k ram
		// ----------------------------------------
		download(8'h03, 8'h02, 8'h03);
		bank_sweep();
		cpu_store(16'h4000, 8'h03); // upper rom lines, masked off by the 128k size
		cpu_store(16'h2000, 8'h06);
		read_range(16'h4000, 2);
		read_range(16'ha000, 2); // ram locked
		wr_before = mem_writes;
		cpu_store(16'ha000, 8'h5a);
		check_eq(mem_writes, wr_before, "store with ram disabled reached memory");
		cpu_store(16'h0000, 8'h0a);
		cpu_store(16'h6000, 8'h01); // mode 1, ram banking on
		cpu_store(16'h4000, 8'h02);
		cpu_store(16'ha010, 8'hc3);
		cpu_store(16'ha011, 8'h3c);
		check_eq(mem_word(24'h102008), 16'h3cc3, "cart ram bank 2 word");
		read_range(16'ha010, 2);
		cpu_store(16'h6000, 8'h00); // mode 0 forces ram bank 0
		read_range(16'ha010, 2);

		// mbc2 with its 512x4 ram
		download(8'h06, 8'h01, 8'h00);
		cpu_store(16'h0000, 8'h0a);
		cpu_store(16'ha003, 8'h97);
		read_range(16'ha000, 8);
		read_range(16'ha1fc, 8); // runs past the end of the chip ram

		// mbc3, clock select unmaps the ram
		download(8'h10, 8'h03, 8'h03);
		cpu_store(16'h0000, 8'h0a);
		cpu_store(16'h4000, 8'h01);
		cpu_store(16'ha020, 8'h77);
		read_range(16'ha020, 2);
		cpu_store(16'h4000, 8'h08);
		read_range(16'ha000, 4);
		cpu_store(16'h4000, 8'h01);
		read_range(16'ha020, 2);

		// mbc5 may select rom bank 0
		download(8'h1b, 8'h05, 8'h02);
		cpu_store(16'h2000, 8'h00);
		read_range(16'h4000, 4);
		cpu_store(16'h2000, 8'h45);
		read_range(16'h4000, 2);

		// a new image brings the bank back to 1
		download(8'h1b, 8'h05, 8'h02);
		read_range(16'h4000, 4);

		if (errors == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* files.f */
+incdir+include
src/cart_pkg.sv
src/ce_divider.sv
src/download_fsm.sv
src/cart_header.sv
src/mbc_regs.sv
src/cart_mapper.sv
src/cart_top.sv
verification/cart_tb.sv

/* Bender.yml */
package:
  name: cart_core

sources:
  - include_dirs:
      - include
    files:
      - src/cart_pkg.sv
      - src/ce_divider.sv
      - src/download_fsm.sv
      - src/cart_header.sv
      - src/mbc_regs.sv
      - src/cart_mapper.sv
      - src/cart_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/cart_tb.sv
